// ==== hw/cluster_periph_pkg.sv ====
// Shared definitions for the cluster peripheral block
// Sizes and bus types, event source indices, address map,
// register offsets and reset values of the boot address

`default_nettype none

package cluster_periph_pkg;

  // Sizes
  localparam int unsigned NB_CORES  = 4;
  localparam int unsigned ID_WIDTH  = NB_CORES + 1;
  localparam int unsigned NB_EVENTS = 4;

  typedef logic [31:0]          data_t;
  typedef logic [31:0]          addr_t;
  typedef logic [ID_WIDTH-1:0]  id_t;
  typedef logic [NB_CORES-1:0]  core_vec_t;
  typedef logic [NB_EVENTS-1:0] event_vec_t;
  typedef logic [1:0]           event_id_t;

  // Event source positions inside a core's pending vector
  localparam int unsigned EVT_TIMER = 0;
  localparam int unsigned EVT_MBOX  = 1;
  localparam int unsigned EVT_DMA   = 2;
  localparam int unsigned EVT_HWPE  = 3;

  // Peripheral select, taken from address bits 11:10
  typedef enum logic [1:0] {
    SEL_CTRL  = 2'd0,
    SEL_TIMER = 2'd1,
    SEL_EVENT = 2'd2,
    SEL_NONE  = 2'd3
  } periph_sel_e;

  localparam data_t UNMAPPED_RDATA = 32'hDEADB33F;

  // Control unit, word index from bits 3:2
  localparam logic [1:0] CTRL_EOC       = 2'd0;
  localparam logic [1:0] CTRL_FETCH_EN  = 2'd1;
  localparam logic [1:0] CTRL_BOOT_ADDR = 2'd2;
  localparam logic [1:0] CTRL_CG_EN     = 2'd3;
  localparam data_t      ROM_BOOT_ADDR  = 32'h1A000000;
  localparam data_t      BOOT_ADDR      = 32'h1C000000;

  // Timer
  localparam logic [1:0] TMR_COUNT   = 2'd0;
  localparam logic [1:0] TMR_COMPARE = 2'd1;
  localparam logic [1:0] TMR_CTRL    = 2'd2;

  // Event unit, core from bits 7:4 and register from bits 3:2
  localparam logic [1:0] EU_MASK    = 2'd0;
  localparam logic [1:0] EU_PENDING = 2'd1;
  localparam logic [1:0] EU_CLEAR   = 2'd2;

endpackage

`default_nettype wire

// ==== hw/periph_target_if.sv ====
// Decoded target bus between the address decoder and one peripheral
// Initiator and target modports

`timescale 1ns/1ns
`default_nettype none

interface periph_target_if;
  import cluster_periph_pkg::*;

  logic       req;
  // High for a read, low for a write
  logic       wen;
  logic [9:0] offset;
  data_t      wdata;
  // Addressed register, valid whenever req and wen are high
  data_t      rdata;

  modport initiator (
    output req,
    output wen,
    output offset,
    output wdata,
    input  rdata
  );

  modport target (
    input  req,
    input  wen,
    input  offset,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== hw/periph_decoder.sv ====
// Input side of the peripheral bus
// Address decode into one target bus per peripheral, plus the select
// that the response side needs

`timescale 1ns/1ns
`default_nettype none

module periph_decoder (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            req_i,
  input  cluster_periph_pkg::addr_t       add_i,
  input  logic                            wen_i,
  input  cluster_periph_pkg::data_t       wdata_i,
  periph_target_if.initiator              ctrl_o,
  periph_target_if.initiator              timer_o,
  periph_target_if.initiator              event_o,
  output cluster_periph_pkg::periph_sel_e sel_o
);
  import cluster_periph_pkg::*;

  assign sel_o = periph_sel_e'(add_i[11:10]);

  // One request line per target, SEL_NONE reaches nobody
  assign ctrl_o.req  = req_i && (sel_o == SEL_CTRL);
  assign timer_o.req = req_i && (sel_o == SEL_TIMER);
  assign event_o.req = req_i && (sel_o == SEL_EVENT);

  // Command fields are shared by all targets
  assign ctrl_o.wen     = wen_i;
  assign ctrl_o.offset  = add_i[9:0];
  assign ctrl_o.wdata   = wdata_i;

  assign timer_o.wen    = wen_i;
  assign timer_o.offset = add_i[9:0];
  assign timer_o.wdata  = wdata_i;

  assign event_o.wen    = wen_i;
  assign event_o.offset = add_i[9:0];
  assign event_o.wdata  = wdata_i;

  // A single bus access must never reach two peripherals
  a_one_target : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({ctrl_o.req, timer_o.req, event_o.req})
  );

endmodule

`default_nettype wire

// ==== hw/cluster_ctrl_unit.sv ====
// Cluster control unit
// End of computation, per-core fetch enable, boot address and
// cluster clock gate enable, all read and written over the target bus

`timescale 1ns/1ns
`default_nettype none

module cluster_ctrl_unit (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          en_sa_boot_i,
  input  logic                          fetch_en_i,
  periph_target_if.target               bus_i,
  output logic                          eoc_o,
  output logic                          cluster_cg_en_o,
  output cluster_periph_pkg::core_vec_t fetch_enable_o,
  output cluster_periph_pkg::data_t     boot_addr_o
);
  import cluster_periph_pkg::*;

  logic       eoc_q;
  logic       cg_en_q;
  core_vec_t  fetch_en_q;
  data_t      boot_addr_q;
  logic       wr;
  logic [1:0] reg_idx;

  assign wr      = bus_i.req && !bus_i.wen;
  assign reg_idx = bus_i.offset[3:2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q       <= 1'b0;
      cg_en_q     <= 1'b0;
      fetch_en_q  <= '0;
      // Standalone boot starts from ROM
      boot_addr_q <= en_sa_boot_i ? ROM_BOOT_ADDR : BOOT_ADDR;
    end else if (wr) begin
      case (reg_idx)
        CTRL_EOC:       eoc_q       <= bus_i.wdata[0];
        CTRL_FETCH_EN:  fetch_en_q  <= bus_i.wdata[NB_CORES-1:0];
        CTRL_BOOT_ADDR: boot_addr_q <= bus_i.wdata;
        CTRL_CG_EN:     cg_en_q     <= bus_i.wdata[0];
        default: ;
      endcase
    end
  end

  // Readback shows the stored bits, without the external fetch enable
  always_comb begin
    case (reg_idx)
      CTRL_EOC:       bus_i.rdata = data_t'(eoc_q);
      CTRL_FETCH_EN:  bus_i.rdata = data_t'(fetch_en_q);
      CTRL_BOOT_ADDR: bus_i.rdata = boot_addr_q;
      default:        bus_i.rdata = data_t'(cg_en_q);
    endcase
  end

  assign eoc_o           = eoc_q;
  assign cluster_cg_en_o = cg_en_q;
  assign boot_addr_o     = boot_addr_q;
  // External fetch enable starts every core at once
  assign fetch_enable_o  = fetch_en_q | {NB_CORES{fetch_en_i}};

endmodule

`default_nettype wire

// ==== hw/cluster_timer.sv ====
// Cluster timer
// 32-bit up counter with compare match, event pulse on each match
// and busy flag while the counter is enabled

`timescale 1ns/1ns
`default_nettype none

module cluster_timer (
  input  logic            clk_i,
  input  logic            rst_n_i,
  periph_target_if.target bus_i,
  output logic            evt_o,
  output logic            busy_o
);
  import cluster_periph_pkg::*;

  data_t      count_q;
  data_t      compare_q;
  logic       enable_q;
  logic       evt_q;
  logic       hit;
  logic       wr;
  logic [1:0] reg_idx;

  assign wr      = bus_i.req && !bus_i.wen;
  assign reg_idx = bus_i.offset[3:2];
  assign hit     = enable_q && (count_q == compare_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
      evt_q     <= 1'b0;
    end else begin
      // With compare at 0 every cycle hits, so the pulse alternates
      evt_q <= hit && !evt_q;
      if (wr && reg_idx == TMR_COUNT) begin
        count_q <= bus_i.wdata;
      end else if (hit) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr && reg_idx == TMR_COMPARE) compare_q <= bus_i.wdata;
      if (wr && reg_idx == TMR_CTRL)    enable_q  <= bus_i.wdata[0];
    end
  end

  always_comb begin
    case (reg_idx)
      TMR_COUNT:   bus_i.rdata = count_q;
      TMR_COMPARE: bus_i.rdata = compare_q;
      TMR_CTRL:    bus_i.rdata = data_t'(enable_q);
      default:     bus_i.rdata = '0;
    endcase
  end

  assign evt_o  = evt_q;
  assign busy_o = enable_q;

  a_evt_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) evt_o |=> !evt_o
  );

endmodule

`default_nettype wire

// ==== hw/event_unit.sv ====
// Event unit
// Per-core pending and mask registers, interrupt request with the id of
// the lowest pending enabled event, acknowledge and software clear

`timescale 1ns/1ns
`default_nettype none

module event_unit (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  input  logic                                                         timer_evt_i,
  input  logic                                                         mbox_irq_i,
  input  cluster_periph_pkg::core_vec_t                                dma_event_i,
  input  cluster_periph_pkg::core_vec_t                                hwpe_event_i,
  input  cluster_periph_pkg::core_vec_t                                irq_ack_i,
  input  cluster_periph_pkg::event_id_t [cluster_periph_pkg::NB_CORES-1:0] irq_ack_id_i,
  periph_target_if.target                                              bus_i,
  output cluster_periph_pkg::core_vec_t                                irq_req_o,
  output cluster_periph_pkg::event_id_t [cluster_periph_pkg::NB_CORES-1:0] irq_id_o
);
  import cluster_periph_pkg::*;

  event_vec_t [NB_CORES-1:0] mask_q;
  event_vec_t [NB_CORES-1:0] pending_q;
  event_vec_t [NB_CORES-1:0] src;
  event_vec_t [NB_CORES-1:0] clr;
  event_vec_t [NB_CORES-1:0] active;
  logic [3:0]                core_idx;
  logic [1:0]                reg_idx;
  logic                      wr;

  assign core_idx = bus_i.offset[7:4];
  assign reg_idx  = bus_i.offset[3:2];
  assign wr       = bus_i.req && !bus_i.wen;

  // **************************************************************************
  // Event sources and clear requests per core
  // **************************************************************************
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      // Timer and mailbox are broadcast, DMA and HWPE are private
      src[c]            = '0;
      src[c][EVT_TIMER] = timer_evt_i;
      src[c][EVT_MBOX]  = mbox_irq_i;
      src[c][EVT_DMA]   = dma_event_i[c];
      src[c][EVT_HWPE]  = hwpe_event_i[c];

      clr[c] = '0;
      if (irq_ack_i[c]) clr[c][irq_ack_id_i[c]] = 1'b1;
      if (wr && core_idx == c && reg_idx == EU_CLEAR) begin
        clr[c] = clr[c] | bus_i.wdata[NB_EVENTS-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mask_q    <= '0;
      pending_q <= '0;
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        if (wr && core_idx == c && reg_idx == EU_MASK) begin
          mask_q[c] <= bus_i.wdata[NB_EVENTS-1:0];
        end
        // A new event wins over a clear in the same cycle
        pending_q[c] <= (pending_q[c] & ~clr[c]) | src[c];
      end
    end
  end

  // **************************************************************************
  // Interrupt request and readback
  // **************************************************************************
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      active[c]    = pending_q[c] & mask_q[c];
      irq_req_o[c] = |active[c];
      irq_id_o[c]  = '0;
      // Downward scan so the lowest index is left
      for (int e = NB_EVENTS - 1; e >= 0; e--) begin
        if (active[c][e]) irq_id_o[c] = event_id_t'(e);
      end
    end
  end

  always_comb begin
    bus_i.rdata = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      if (core_idx == c) begin
        if (reg_idx == EU_MASK)    bus_i.rdata = data_t'(mask_q[c]);
        if (reg_idx == EU_PENDING) bus_i.rdata = data_t'(pending_q[c]);
      end
    end
  end

  // A core only acknowledges an interrupt it was offered
  for (genvar c = 0; c < NB_CORES; c++) begin : gen_ack_chk
    a_ack_with_req : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) irq_ack_i[c] |-> irq_req_o[c]
    );
  end

endmodule

`default_nettype wire

// ==== hw/periph_resp_mux.sv ====
// Output side of the peripheral bus
// Read data select by target and registered response with id

`timescale 1ns/1ns
`default_nettype none

module periph_resp_mux (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            req_i,
  input  logic                            wen_i,
  input  cluster_periph_pkg::id_t         id_i,
  input  cluster_periph_pkg::periph_sel_e sel_i,
  input  cluster_periph_pkg::data_t       ctrl_rdata_i,
  input  cluster_periph_pkg::data_t       timer_rdata_i,
  input  cluster_periph_pkg::data_t       event_rdata_i,
  output logic                            r_valid_o,
  output cluster_periph_pkg::data_t       r_rdata_o,
  output cluster_periph_pkg::id_t         r_id_o
);
  import cluster_periph_pkg::*;

  data_t rdata_d;

  // Writes answer with zero data
  always_comb begin
    rdata_d = '0;
    if (wen_i) begin
      case (sel_i)
        SEL_CTRL:  rdata_d = ctrl_rdata_i;
        SEL_TIMER: rdata_d = timer_rdata_i;
        SEL_EVENT: rdata_d = event_rdata_i;
        default:   rdata_d = UNMAPPED_RDATA;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) r_valid_o <= 1'b0;
    else          r_valid_o <= req_i;
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      r_rdata_o <= rdata_d;
      r_id_o    <= id_i;
    end
  end

  // Every request is answered on the next cycle with its own id
  a_resp_next : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_i |=> r_valid_o && (r_id_o == $past(id_i))
  );

endmodule

`default_nettype wire

// ==== hw/cluster_peripherals.sv ====
// Cluster peripheral block top level
// Address decoder, control unit, timer, event unit and response side
// behind one core-side peripheral bus

`timescale 1ns/1ns
`default_nettype none

module cluster_peripherals (
  input  logic                                                         clk_i,
  input  logic                                                         rst_n_i,
  input  logic                                                         en_sa_boot_i,
  input  logic                                                         fetch_en_i,
  input  logic                                                         mbox_irq_i,
  input  cluster_periph_pkg::core_vec_t                                dma_event_i,
  input  cluster_periph_pkg::core_vec_t                                hwpe_event_i,
  input  cluster_periph_pkg::core_vec_t                                irq_ack_i,
  input  cluster_periph_pkg::event_id_t [cluster_periph_pkg::NB_CORES-1:0] irq_ack_id_i,

  // Core-side peripheral bus
  input  logic                                                         periph_req_i,
  input  cluster_periph_pkg::addr_t                                    periph_add_i,
  input  logic                                                         periph_wen_i,
  input  cluster_periph_pkg::data_t                                    periph_wdata_i,
  input  cluster_periph_pkg::id_t                                      periph_id_i,
  output logic                                                         periph_gnt_o,
  output logic                                                         periph_r_valid_o,
  output cluster_periph_pkg::data_t                                    periph_r_rdata_o,
  output cluster_periph_pkg::id_t                                      periph_r_id_o,

  output logic                                                         eoc_o,
  output logic                                                         cluster_cg_en_o,
  output cluster_periph_pkg::core_vec_t                                fetch_enable_o,
  output cluster_periph_pkg::data_t                                    boot_addr_o,
  output logic                                                         busy_o,
  output cluster_periph_pkg::core_vec_t                                irq_req_o,
  output cluster_periph_pkg::event_id_t [cluster_periph_pkg::NB_CORES-1:0] irq_id_o
);
  import cluster_periph_pkg::*;

  periph_sel_e periph_sel;
  logic        timer_evt;

  periph_target_if ctrl_bus ();
  periph_target_if timer_bus ();
  periph_target_if event_bus ();

  // No back-pressure, every request is granted at once
  assign periph_gnt_o = periph_req_i;

  // **************************************************************************
  // Input side
  // **************************************************************************
  periph_decoder periph_decoder_i (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .req_i   ( periph_req_i   ),
    .add_i   ( periph_add_i   ),
    .wen_i   ( periph_wen_i   ),
    .wdata_i ( periph_wdata_i ),
    .ctrl_o  ( ctrl_bus       ),
    .timer_o ( timer_bus      ),
    .event_o ( event_bus      ),
    .sel_o   ( periph_sel     )
  );

  // **************************************************************************
  // Peripherals
  // **************************************************************************
  cluster_ctrl_unit cluster_ctrl_unit_i (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .en_sa_boot_i    ( en_sa_boot_i    ),
    .fetch_en_i      ( fetch_en_i      ),
    .bus_i           ( ctrl_bus        ),
    .eoc_o           ( eoc_o           ),
    .cluster_cg_en_o ( cluster_cg_en_o ),
    .fetch_enable_o  ( fetch_enable_o  ),
    .boot_addr_o     ( boot_addr_o     )
  );

  cluster_timer cluster_timer_i (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .bus_i   ( timer_bus ),
    .evt_o   ( timer_evt ),
    .busy_o  ( busy_o    )
  );

  event_unit event_unit_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .timer_evt_i  ( timer_evt    ),
    .mbox_irq_i   ( mbox_irq_i   ),
    .dma_event_i  ( dma_event_i  ),
    .hwpe_event_i ( hwpe_event_i ),
    .irq_ack_i    ( irq_ack_i    ),
    .irq_ack_id_i ( irq_ack_id_i ),
    .bus_i        ( event_bus    ),
    .irq_req_o    ( irq_req_o    ),
    .irq_id_o     ( irq_id_o     )
  );

  // **************************************************************************
  // Output side
  // **************************************************************************
  periph_resp_mux periph_resp_mux_i (
    .clk_i         ( clk_i            ),
    .rst_n_i       ( rst_n_i          ),
    .req_i         ( periph_req_i     ),
    .wen_i         ( periph_wen_i     ),
    .id_i          ( periph_id_i      ),
    .sel_i         ( periph_sel       ),
    .ctrl_rdata_i  ( ctrl_bus.rdata   ),
    .timer_rdata_i ( timer_bus.rdata  ),
    .event_rdata_i ( event_bus.rdata  ),
    .r_valid_o     ( periph_r_valid_o ),
    .r_rdata_o     ( periph_r_rdata_o ),
    .r_id_o        ( periph_r_id_o    )
  );

endmodule

`default_nettype wire

// ==== testbench/tb_cluster_peripherals.sv ====
// Testbench for the cluster peripheral block
// Clock and reset, bus and event drivers, register and event model,
// typed compare tasks and a watchdog

`timescale 1ns/1ns
`default_nettype none

module tb_cluster_peripherals;
  import cluster_periph_pkg::*;

  localparam int SEED    = 16593;
  localparam int N_CTRL  = 20;
  localparam int N_BURST = 32;
  localparam int N_EVT   = 16;
  localparam int N_CLR   = 12;
  // Bus operations of all tests with their idle cycles
  localparam int NUM_OPS         = 2 * N_CTRL + N_BURST + 40 + 8 * N_EVT + 6 * N_CLR;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 10 + 1000;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      en_sa_boot_i;
  logic                      fetch_en_i;
  logic                      mbox_irq_i;
  core_vec_t                 dma_event_i;
  core_vec_t                 hwpe_event_i;
  core_vec_t                 irq_ack_i;
  event_id_t [NB_CORES-1:0]  irq_ack_id_i;
  logic                      periph_req_i;
  addr_t                     periph_add_i;
  logic                      periph_wen_i;
  data_t                     periph_wdata_i;
  id_t                       periph_id_i;
  logic                      periph_gnt_o;
  logic                      periph_r_valid_o;
  data_t                     periph_r_rdata_o;
  id_t                       periph_r_id_o;
  logic                      eoc_o;
  logic                      cluster_cg_en_o;
  core_vec_t                 fetch_enable_o;
  data_t                     boot_addr_o;
  logic                      busy_o;
  core_vec_t                 irq_req_o;
  event_id_t [NB_CORES-1:0]  irq_id_o;

  // Response expected at the next falling edge
  logic       exp_valid;
  id_t        exp_id;
  data_t      exp_rdata;

  // Register and event model
  logic       eoc_m;
  logic       cg_m;
  core_vec_t  fetch_m;
  data_t      boot_m;
  event_vec_t mask_m [NB_CORES];
  event_vec_t pend_m [NB_CORES];

  cluster_peripherals dut0 (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .en_sa_boot_i     ( en_sa_boot_i     ),
    .fetch_en_i       ( fetch_en_i       ),
    .mbox_irq_i       ( mbox_irq_i       ),
    .dma_event_i      ( dma_event_i      ),
    .hwpe_event_i     ( hwpe_event_i     ),
    .irq_ack_i        ( irq_ack_i        ),
    .irq_ack_id_i     ( irq_ack_id_i     ),
    .periph_req_i     ( periph_req_i     ),
    .periph_add_i     ( periph_add_i     ),
    .periph_wen_i     ( periph_wen_i     ),
    .periph_wdata_i   ( periph_wdata_i   ),
    .periph_id_i      ( periph_id_i      ),
    .periph_gnt_o     ( periph_gnt_o     ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .periph_r_rdata_o ( periph_r_rdata_o ),
    .periph_r_id_o    ( periph_r_id_o    ),
    .eoc_o            ( eoc_o            ),
    .cluster_cg_en_o  ( cluster_cg_en_o  ),
    .fetch_enable_o   ( fetch_enable_o   ),
    .boot_addr_o      ( boot_addr_o      ),
    .busy_o           ( busy_o           ),
    .irq_req_o        ( irq_req_o        ),
    .irq_id_o         ( irq_id_o         )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    stop_on_error("error: watchdog expired before the tests completed");
  end

  // **************************************************************************
  // Compare tasks and model helpers
  // **************************************************************************
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic verify_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic match_cores(input string name, input core_vec_t got, input core_vec_t exp);
    if (got !== exp) stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic test_event_id(input string name, input event_id_t got, input event_id_t exp);
    if (got !== exp) stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp) stop_on_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic addr_t make_addr(input periph_sel_e sel, input int core, input logic [1:0] idx);
    addr_t a;
    a        = '0;
    a[11:10] = sel;
    a[7:4]   = core[3:0];
    a[3:2]   = idx;
    return a;
  endfunction

  function automatic event_id_t lowest_id(input event_vec_t v);
    event_id_t id;
    logic      found;
    id    = '0;
    found = 1'b0;
    for (int e = 0; e < NB_EVENTS; e++) begin
      if (v[e] && !found) begin
        id    = event_id_t'(e);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  function automatic data_t ctrl_value(input logic [1:0] idx);
    case (idx)
      CTRL_EOC:       return data_t'(eoc_m);
      CTRL_FETCH_EN:  return data_t'(fetch_m);
      CTRL_BOOT_ADDR: return boot_m;
      default:        return data_t'(cg_m);
    endcase
  endfunction

  task automatic response_compare;
    expect_bit("periph_gnt_o", periph_gnt_o, periph_req_i);
    expect_bit("periph_r_valid_o", periph_r_valid_o, exp_valid);
    if (exp_valid) begin
      verify_id("periph_r_id_o", periph_r_id_o, exp_id);
      check_data("periph_r_rdata_o", periph_r_rdata_o, exp_rdata);
    end
  endtask

  task automatic ctrl_outputs_compare;
    expect_bit("eoc_o", eoc_o, eoc_m);
    expect_bit("cluster_cg_en_o", cluster_cg_en_o, cg_m);
    match_cores("fetch_enable_o", fetch_enable_o, fetch_m | {NB_CORES{fetch_en_i}});
    check_data("boot_addr_o", boot_addr_o, boot_m);
  endtask

  task automatic irq_model_compare;
    event_vec_t act;
    core_vec_t  exp_req;
    for (int c = 0; c < NB_CORES; c++) begin
      act        = pend_m[c] & mask_m[c];
      exp_req[c] = |act;
      if (|act) test_event_id($sformatf("irq_id_o[%0d]", c), irq_id_o[c], lowest_id(act));
    end
    match_cores("irq_req_o", irq_req_o, exp_req);
  endtask

  // **************************************************************************
  // Drivers, all acting on the falling edge
  // **************************************************************************
  task automatic next_cycle;
    @(negedge clk_i);
    response_compare();
    periph_req_i = 1'b0;
    mbox_irq_i   = 1'b0;
    dma_event_i  = '0;
    hwpe_event_i = '0;
    irq_ack_i    = '0;
    exp_valid    = 1'b0;
  endtask

  task automatic bus_op(input logic wen, input addr_t addr, input data_t wdata, input data_t exp_rd);
    next_cycle();
    periph_req_i   = 1'b1;
    periph_add_i   = addr;
    periph_wen_i   = wen;
    periph_wdata_i = wdata;
    periph_id_i    = id_t'($urandom);
    exp_valid      = 1'b1;
    exp_id         = periph_id_i;
    exp_rdata      = wen ? exp_rd : '0;
  endtask

  task automatic read_pending(input int c);
    bus_op(1'b1, make_addr(SEL_EVENT, c, EU_PENDING), '0, data_t'(pend_m[c]));
  endtask

  task automatic reset_dut(input logic sa_boot);
    @(negedge clk_i);
    rst_n_i      = 1'b0;
    en_sa_boot_i = sa_boot;
    periph_req_i = 1'b0;
    fetch_en_i   = 1'b0;
    exp_valid    = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    eoc_m   = 1'b0;
    cg_m    = 1'b0;
    fetch_m = '0;
    boot_m  = sa_boot ? ROM_BOOT_ADDR : BOOT_ADDR;
    for (int c = 0; c < NB_CORES; c++) begin
      mask_m[c] = '0;
      pend_m[c] = '0;
    end
    ctrl_outputs_compare();
    expect_bit("busy_o", busy_o, 1'b0);
    expect_bit("periph_r_valid_o", periph_r_valid_o, 1'b0);
    irq_model_compare();
  endtask

  task automatic pulse_events;
    logic      mbox;
    core_vec_t dma;
    core_vec_t hwpe;
    next_cycle();
    irq_model_compare();
    mbox         = ($urandom % 3) == 0;
    dma          = core_vec_t'($urandom & $urandom);
    hwpe         = core_vec_t'($urandom & $urandom);
    mbox_irq_i   = mbox;
    dma_event_i  = dma;
    hwpe_event_i = hwpe;
    for (int c = 0; c < NB_CORES; c++) begin
      pend_m[c][EVT_MBOX] = pend_m[c][EVT_MBOX] | mbox;
      pend_m[c][EVT_DMA]  = pend_m[c][EVT_DMA] | dma[c];
      pend_m[c][EVT_HWPE] = pend_m[c][EVT_HWPE] | hwpe[c];
    end
  endtask

  // Acknowledge the current id on a random subset of requesting cores
  task automatic send_acks;
    event_vec_t act;
    event_id_t  id;
    next_cycle();
    irq_model_compare();
    for (int c = 0; c < NB_CORES; c++) begin
      act = pend_m[c] & mask_m[c];
      if (act != '0 && ($urandom % 2) == 1) begin
        id              = lowest_id(act);
        irq_ack_i[c]    = 1'b1;
        irq_ack_id_i[c] = id;
        pend_m[c][id]   = 1'b0;
      end
    end
  endtask

  // **************************************************************************
  // Test sequence
  // **************************************************************************
  initial begin
    logic       boot_sel;
    logic [1:0] idx;
    data_t      wd;
    data_t      cmp;
    addr_t      a;
    int         c;
    int         kind;

    rst_n_i        = 1'b0;
    en_sa_boot_i   = 1'b0;
    fetch_en_i     = 1'b0;
    mbox_irq_i     = 1'b0;
    dma_event_i    = '0;
    hwpe_event_i   = '0;
    irq_ack_i      = '0;
    irq_ack_id_i   = '0;
    periph_req_i   = 1'b0;
    periph_add_i   = '0;
    periph_wen_i   = 1'b0;
    periph_wdata_i = '0;
    periph_id_i    = '0;
    exp_valid      = 1'b0;
    exp_id         = '0;
    exp_rdata      = '0;
    void'($urandom(SEED));

    // Both boot address reset values
    boot_sel = 1'($urandom % 2);
    reset_dut(boot_sel);
    reset_dut(!boot_sel);

    // Control registers
    for (int i = 0; i < N_CTRL; i++) begin
      idx = 2'($urandom % 4);
      wd  = $urandom;
      bus_op(1'b0, make_addr(SEL_CTRL, 0, idx), wd, '0);
      case (idx)
        CTRL_EOC:       eoc_m   = wd[0];
        CTRL_FETCH_EN:  fetch_m = wd[NB_CORES-1:0];
        CTRL_BOOT_ADDR: boot_m  = wd;
        default:        cg_m    = wd[0];
      endcase
      fetch_en_i = 1'($urandom % 2);
      next_cycle();
      ctrl_outputs_compare();
      bus_op(1'b1, make_addr(SEL_CTRL, 0, idx), '0, ctrl_value(idx));
    end

    // Back-to-back requests, unmapped reads and writes mixed with mapped reads
    for (int i = 0; i < N_BURST; i++) begin
      kind     = $urandom % 3;
      a        = $urandom;
      a[11:10] = SEL_NONE;
      if (kind == 0) bus_op(1'b1, a, '0, UNMAPPED_RDATA);
      else if (kind == 1) bus_op(1'b0, a, data_t'($urandom), '0);
      else bus_op(1'b1, make_addr(SEL_CTRL, 0, CTRL_BOOT_ADDR), '0, boot_m);
    end

    // Timer match sets the timer event of every core
    cmp = 3 + ($urandom % 8);
    bus_op(1'b0, make_addr(SEL_TIMER, 0, TMR_COMPARE), cmp, '0);
    bus_op(1'b0, make_addr(SEL_TIMER, 0, TMR_CTRL), 32'd1, '0);
    next_cycle();
    expect_bit("busy_o", busy_o, 1'b1);
    repeat (cmp + 4) next_cycle();
    for (int k = 0; k < NB_CORES; k++) begin
      pend_m[k][EVT_TIMER] = 1'b1;
      read_pending(k);
    end
    bus_op(1'b0, make_addr(SEL_TIMER, 0, TMR_CTRL), 32'd0, '0);
    repeat (3) next_cycle();
    expect_bit("busy_o", busy_o, 1'b0);
    wd = $urandom;
    bus_op(1'b0, make_addr(SEL_TIMER, 0, TMR_COUNT), wd, '0);
    bus_op(1'b1, make_addr(SEL_TIMER, 0, TMR_COUNT), '0, wd);
    repeat (2) next_cycle();
    bus_op(1'b1, make_addr(SEL_TIMER, 0, TMR_COUNT), '0, wd);
    bus_op(1'b1, make_addr(SEL_TIMER, 0, TMR_COMPARE), '0, cmp);
    bus_op(1'b1, make_addr(SEL_TIMER, 0, TMR_CTRL), '0, 32'd0);

    // Masks and event pulses
    for (int i = 0; i < N_EVT; i++) begin
      c  = $urandom % NB_CORES;
      wd = $urandom;
      bus_op(1'b0, make_addr(SEL_EVENT, c, EU_MASK), wd, '0);
      mask_m[c] = wd[NB_EVENTS-1:0];
      bus_op(1'b1, make_addr(SEL_EVENT, c, EU_MASK), '0, data_t'(mask_m[c]));
      pulse_events();
      next_cycle();
      irq_model_compare();
      for (int k = 0; k < NB_CORES; k++) read_pending(k);
    end

    // Acknowledge and software clear
    for (int i = 0; i < N_CLR; i++) begin
      pulse_events();
      send_acks();
      next_cycle();
      irq_model_compare();
      c  = $urandom % NB_CORES;
      wd = $urandom;
      bus_op(1'b0, make_addr(SEL_EVENT, c, EU_CLEAR), wd, '0);
      pend_m[c] = pend_m[c] & ~wd[NB_EVENTS-1:0];
      read_pending(c);
      next_cycle();
      irq_model_compare();
    end

    next_cycle();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cluster_peripherals.f ====
hw/cluster_periph_pkg.sv
hw/periph_target_if.sv
hw/periph_decoder.sv
hw/cluster_ctrl_unit.sv
hw/cluster_timer.sv
hw/event_unit.sv
hw/periph_resp_mux.sv
hw/cluster_peripherals.sv
testbench/tb_cluster_peripherals.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the cluster peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cluster_peripherals \
  -Mdir obj_dir \
  -f cluster_peripherals.f
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_cluster_peripherals)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
